// ==== reg_map_pkg.sv ====
package reg_map_pkg;

    // index width and word width seen by the core
    localparam int reg_idx_w = 4;
    localparam int word_w = 16;

    // general purpose registers sit at the bottom of the map
    localparam int gp_count = 4;
    localparam logic [reg_idx_w-1:0] r_gp0 = 4'd0;

    // return stack, top of stack on read
    localparam logic [reg_idx_w-1:0] r_rstk = 4'd4;

    // board i/o
    localparam logic [reg_idx_w-1:0] r_leds = 4'd5;
    // read only, key bits 1:0
    localparam logic [reg_idx_w-1:0] r_keys = 4'd6;

    // bus master, load writedata last since it starts the write
    localparam logic [reg_idx_w-1:0] r_av_address = 4'd7;
    localparam logic [reg_idx_w-1:0] r_av_writedata = 4'd8;
    // read only status word
    localparam logic [reg_idx_w-1:0] r_av_status = 4'd9;
    localparam int av_busy_bit = 0;

    // indices 10..15 are unused, read zero

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

    // write-only memory mapped bus
    localparam int av_addr_w = 16;
    localparam int av_data_w = 16;

    // master state
    // idle: nothing pending
    // writing: av_write held until slave drops waitrequest
    typedef enum logic {
        idle    = 1'b0,
        writing = 1'b1
    } av_state_t;

endpackage

// ==== reset_sync.sv ====
`timescale 1ns/100ps

module reset_sync (
    input  logic sysclk,
    input  logic arst_n,
    output logic rst_n
);

    // three stage release chain
    logic [2:0] sync_q;

    // clears at once on arst_n, shifts ones in afterwards
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], 1'b1};
        end
    end

    // released on the third edge after arst_n rises
    assign rst_n = sync_q[2];

endmodule

// ==== reg_access_decode.sv ====
`timescale 1ns/100ps

module reg_access_decode #(
    parameter int led_width = 8
) (
    input  logic [reg_map_pkg::reg_idx_w-1:0] reg_sel,
    input  logic                              reg_load,
    input  logic                              reg_read,
    input  logic [reg_map_pkg::word_w-1:0]    gp_value [reg_map_pkg::gp_count],
    input  logic [reg_map_pkg::word_w-1:0]    stk_top,
    input  logic [led_width-1:0]              led_value,
    input  logic [1:0]                        key_value,
    input  logic [bus_pkg::av_addr_w-1:0]     av_addr_value,
    input  logic [bus_pkg::av_data_w-1:0]     av_data_value,
    input  logic                              av_busy,
    output logic [reg_map_pkg::word_w-1:0]    read_data,
    output logic [reg_map_pkg::gp_count-1:0]  gp_load,
    output logic                              stk_push,
    output logic                              stk_pop,
    output logic                              led_load,
    output logic                              av_addr_load,
    output logic                              av_data_load
);

    // load strobes, one per block
    always_comb begin
        for (int i = 0; i < reg_map_pkg::gp_count; i++) begin
            gp_load[i] = reg_load && (reg_sel == reg_map_pkg::r_gp0 + i);
        end
        // a load of the stack is a push
        stk_push = reg_load && (reg_sel == reg_map_pkg::r_rstk);
        led_load = reg_load && (reg_sel == reg_map_pkg::r_leds);
        av_addr_load = reg_load && (reg_sel == reg_map_pkg::r_av_address);
        // starts a bus write in the master
        av_data_load = reg_load && (reg_sel == reg_map_pkg::r_av_writedata);
    end

    // only side effect of a read: popping the stack
    assign stk_pop = reg_read && (reg_sel == reg_map_pkg::r_rstk);

    // read mux, narrow values zero extended
    always_comb begin
        read_data = '0;
        case (reg_sel)
            reg_map_pkg::r_rstk: begin
                read_data = stk_top;
            end
            reg_map_pkg::r_leds: begin
                read_data[led_width-1:0] = led_value;
            end
            reg_map_pkg::r_keys: begin
                read_data[1:0] = key_value;
            end
            reg_map_pkg::r_av_address: begin
                read_data[bus_pkg::av_addr_w-1:0] = av_addr_value;
            end
            reg_map_pkg::r_av_writedata: begin
                read_data[bus_pkg::av_data_w-1:0] = av_data_value;
            end
            reg_map_pkg::r_av_status: begin
                read_data[reg_map_pkg::av_busy_bit] = av_busy;
            end
            default: begin
                // gp window, anything else stays zero
                for (int i = 0; i < reg_map_pkg::gp_count; i++) begin
                    if (reg_sel == reg_map_pkg::r_gp0 + i) begin
                        read_data = gp_value[i];
                    end
                end
            end
        endcase
    end

endmodule

// ==== gp_reg_bank.sv ====
`timescale 1ns/100ps

module gp_reg_bank (
    input  logic                             sysclk,
    input  logic                             rst_n,
    input  logic [reg_map_pkg::gp_count-1:0] gp_load,
    input  logic [reg_map_pkg::word_w-1:0]   load_data,
    output logic [reg_map_pkg::word_w-1:0]   gp_value [reg_map_pkg::gp_count]
);

    // one word per register, each with its own enable
    genvar g;
    generate
        for (g = 0; g < reg_map_pkg::gp_count; g++) begin : gen_gp
            always_ff @(posedge sysclk or negedge rst_n) begin
                if (!rst_n) begin
                    gp_value[g] <= '0;
                end else if (gp_load[g]) begin
                    // visible on read_data after this edge
                    gp_value[g] <= load_data;
                end
            end
        end
    endgenerate

endmodule

// ==== stack_reg.sv ====
`timescale 1ns/100ps

module stack_reg #(
    parameter int stack_depth = 32
) (
    input  logic                           sysclk,
    input  logic                           rst_n,
    input  logic                           stk_push,
    input  logic                           stk_pop,
    input  logic [reg_map_pkg::word_w-1:0] load_data,
    output logic [reg_map_pkg::word_w-1:0] stk_top
);

    localparam int ptr_w = (stack_depth > 1) ? $clog2(stack_depth) : 1;
    localparam int lvl_w = $clog2(stack_depth + 1);

    // entry storage, no reset
    logic [reg_map_pkg::word_w-1:0] mem [stack_depth];

    // pointer at the current top
    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] ptr_up;
    logic [ptr_w-1:0] ptr_dn;
    // number of live entries, saturates at depth
    logic [lvl_w-1:0] level;

    // circular neighbours of the pointer
    always_comb begin
        ptr_up = (ptr == ptr_w'(stack_depth - 1)) ? '0 : ptr + 1'b1;
        ptr_dn = (ptr == '0) ? ptr_w'(stack_depth - 1) : ptr - 1'b1;
    end

    // pointer and fill level
    // push wins if both strobes come together
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
            level <= '0;
        end else if (stk_push) begin
            ptr <= ptr_up;
            // past depth the oldest entry is overwritten
            if (level != lvl_w'(stack_depth)) begin
                level <= level + 1'b1;
            end
        end else if (stk_pop) begin
            ptr <= ptr_dn;
            if (level != '0) begin
                level <= level - 1'b1;
            end
        end
    end

    // new entry goes one slot above the old top
    always_ff @(posedge sysclk) begin
        if (stk_push) begin
            mem[ptr_up] <= load_data;
        end
    end

    // empty stack reads zero, otherwise the entry at the pointer
    assign stk_top = (level == '0) ? '0 : mem[ptr];

endmodule

// ==== io_port_regs.sv ====
`timescale 1ns/100ps

module io_port_regs #(
    parameter int led_width = 8
) (
    input  logic                           sysclk,
    input  logic                           rst_n,
    input  logic                           led_load,
    input  logic [reg_map_pkg::word_w-1:0] load_data,
    input  logic [1:0]                     key,
    output logic [led_width-1:0]           led,
    output logic [1:0]                     key_value
);

    // first synchronizer stage
    logic [1:0] key_meta;

    // led register drives the pins directly
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            led <= '0;
        end else if (led_load) begin
            // upper bits of the word are dropped
            led <= load_data[led_width-1:0];
        end
    end

    // two flops, key shows up in r_keys two edges after it settles
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            key_meta <= '0;
            key_value <= '0;
        end else begin
            key_meta <= key;
            key_value <= key_meta;
        end
    end

endmodule

// ==== av_write_master.sv ====
`timescale 1ns/100ps

module av_write_master (
    input  logic                           sysclk,
    input  logic                           rst_n,
    input  logic                           av_addr_load,
    input  logic                           av_data_load,
    input  logic [reg_map_pkg::word_w-1:0] load_data,
    input  logic                           av_waitrequest,
    output logic [bus_pkg::av_addr_w-1:0]  av_address,
    output logic [bus_pkg::av_data_w-1:0]  av_writedata,
    output logic                           av_write,
    output logic                           av_busy,
    output logic                           mcu_wait
);

    bus_pkg::av_state_t state;

    // address and data registers, readable by the core
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            av_address <= '0;
            av_writedata <= '0;
        end else begin
            if (av_addr_load) begin
                av_address <= load_data;
            end
            if (av_data_load) begin
                av_writedata <= load_data;
            end
        end
    end

    // write sequencing
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bus_pkg::idle;
        end else if (av_data_load) begin
            // can land on the completing edge of the previous write,
            // so a back to back write is never dropped
            state <= bus_pkg::writing;
        end else if (state == bus_pkg::writing && !av_waitrequest) begin
            // slave took the write at this edge
            state <= bus_pkg::idle;
        end
    end

    // strobe held with address and data stable until accepted
    assign av_write = (state == bus_pkg::writing);
    assign av_busy = av_write;

    // stall only while the slave is actually holding off,
    // so a zero-wait slave costs no cycle
    assign mcu_wait = av_write && av_waitrequest;

endmodule

// ==== mcu_io_top.sv ====
`timescale 1ns/100ps

module mcu_io_top #(
    parameter int stack_depth = 32,
    parameter int led_width = 8
) (
    input  logic                              sysclk,
    input  logic                              arst_n,
    // core side
    input  logic [reg_map_pkg::reg_idx_w-1:0] reg_sel,
    input  logic                              reg_load,
    input  logic                              reg_read,
    input  logic [reg_map_pkg::word_w-1:0]    load_data,
    output logic [reg_map_pkg::word_w-1:0]    read_data,
    output logic                              mcu_wait,
    // bus side
    input  logic                              av_waitrequest,
    output logic [bus_pkg::av_addr_w-1:0]     av_address,
    output logic [bus_pkg::av_data_w-1:0]     av_writedata,
    output logic                              av_write,
    // board side
    input  logic [1:0]                        key,
    output logic [led_width-1:0]              led
);

    // synchronized reset for every block
    logic rst_n;

    // strobes from the decoder
    logic [reg_map_pkg::gp_count-1:0] gp_load;
    logic stk_push;
    logic stk_pop;
    logic led_load;
    logic av_addr_load;
    logic av_data_load;

    // block values back into the read mux
    logic [reg_map_pkg::word_w-1:0] gp_value [reg_map_pkg::gp_count];
    logic [reg_map_pkg::word_w-1:0] stk_top;
    logic [1:0] key_value;
    logic av_busy;

    reset_sync reset_sync_i (
        .sysclk (sysclk),
        .arst_n (arst_n),
        .rst_n  (rst_n)
    );

    reg_access_decode #(
        .led_width (led_width)
    ) reg_access_decode_i (
        .reg_sel       (reg_sel),
        .reg_load      (reg_load),
        .reg_read      (reg_read),
        .gp_value      (gp_value),
        .stk_top       (stk_top),
        .led_value     (led),
        .key_value     (key_value),
        .av_addr_value (av_address),
        .av_data_value (av_writedata),
        .av_busy       (av_busy),
        .read_data     (read_data),
        .gp_load       (gp_load),
        .stk_push      (stk_push),
        .stk_pop       (stk_pop),
        .led_load      (led_load),
        .av_addr_load  (av_addr_load),
        .av_data_load  (av_data_load)
    );

    gp_reg_bank gp_reg_bank_i (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .gp_load   (gp_load),
        .load_data (load_data),
        .gp_value  (gp_value)
    );

    stack_reg #(
        .stack_depth (stack_depth)
    ) stack_reg_i (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .stk_push  (stk_push),
        .stk_pop   (stk_pop),
        .load_data (load_data),
        .stk_top   (stk_top)
    );

    io_port_regs #(
        .led_width (led_width)
    ) io_port_regs_i (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .led_load  (led_load),
        .load_data (load_data),
        .key       (key),
        .led       (led),
        .key_value (key_value)
    );

    av_write_master av_write_master_i (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .av_addr_load   (av_addr_load),
        .av_data_load   (av_data_load),
        .load_data      (load_data),
        .av_waitrequest (av_waitrequest),
        .av_address     (av_address),
        .av_writedata   (av_writedata),
        .av_write       (av_write),
        .av_busy        (av_busy),
        .mcu_wait       (mcu_wait)
    );

endmodule

// ==== tb_mcu_io.sv ====
`timescale 1ns/100ps

module tb_mcu_io;

    localparam int stack_depth = 32;
    localparam int led_width = 8;

    logic sysclk;
    logic arst_n;
    logic [reg_map_pkg::reg_idx_w-1:0] reg_sel;
    logic reg_load;
    logic reg_read;
    logic [reg_map_pkg::word_w-1:0] load_data;
    logic [reg_map_pkg::word_w-1:0] read_data;
    logic mcu_wait;
    logic av_waitrequest;
    logic [bus_pkg::av_addr_w-1:0] av_address;
    logic [bus_pkg::av_data_w-1:0] av_writedata;
    logic av_write;
    logic [1:0] key;
    logic [led_width-1:0] led;

    int errors = 0;
    integer seed = 32'h76f1_a14d;
    event hung;

    // bus writes as {address, data}, expected from core loads and seen by the slave
    logic [bus_pkg::av_addr_w+bus_pkg::av_data_w-1:0] exp_writes [$];
    logic [bus_pkg::av_addr_w+bus_pkg::av_data_w-1:0] got_writes [$];
    logic [bus_pkg::av_addr_w-1:0] exp_addr = '0;

    mcu_io_top #(
        .stack_depth (stack_depth),
        .led_width   (led_width)
    ) dut_i (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_sel        (reg_sel),
        .reg_load       (reg_load),
        .reg_read       (reg_read),
        .load_data      (load_data),
        .read_data      (read_data),
        .mcu_wait       (mcu_wait),
        .av_waitrequest (av_waitrequest),
        .av_address     (av_address),
        .av_writedata   (av_writedata),
        .av_write       (av_write),
        .key            (key),
        .led            (led)
    );

    initial begin
        sysclk = 1'b0;
        forever begin
            #20 sysclk = ~sysclk;
        end
    end

    // slave, 0..3 wait states per write, decided on the falling edge
    initial begin : slave_model
        logic [31:0] r;
        int wait_left;
        bit pending;
        wait_left = 0;
        pending = 1'b0;
        av_waitrequest = 1'b0;
        forever begin
            @(negedge sysclk);
            if (av_write && !pending) begin
                pending = 1'b1;
                r = $random(seed);
                wait_left = int'(r[1:0]);
            end
            if (pending && wait_left == 0) begin
                // next rising edge completes the write
                av_waitrequest = 1'b0;
                got_writes.push_back({av_address, av_writedata});
                pending = 1'b0;
            end else if (pending) begin
                av_waitrequest = 1'b1;
                wait_left--;
            end else begin
                av_waitrequest = 1'b0;
            end
        end
    end

    // bus and stall rules, checked on every edge
    stall_match: assert property (@(posedge sysclk) disable iff (!arst_n)
        mcu_wait == (av_write && av_waitrequest))
        else begin
            errors++;
            $display("error %0t: mcu_wait differs from av_write and av_waitrequest", $time);
        end
    write_held: assert property (@(posedge sysclk) disable iff (!arst_n)
        (av_write && av_waitrequest) |=>
        (av_write && $stable(av_address) && $stable(av_writedata)))
        else begin
            errors++;
            $display("error %0t: av_write dropped or address/data moved during wait", $time);
        end
    write_start: assert property (@(posedge sysclk) disable iff (!arst_n)
        (reg_load && reg_sel == reg_map_pkg::r_av_writedata) |=> av_write)
        else begin
            errors++;
            $display("error %0t: write data load did not raise av_write", $time);
        end
    write_end: assert property (@(posedge sysclk) disable iff (!arst_n)
        (av_write && !av_waitrequest && !(reg_load && reg_sel == reg_map_pkg::r_av_writedata))
        |=> !av_write)
        else begin
            errors++;
            $display("error %0t: av_write still high after the accepting edge", $time);
        end
    busy_bit: assert property (@(posedge sysclk) disable iff (!arst_n)
        (reg_sel == reg_map_pkg::r_av_status) |-> (read_data[0] == av_write))
        else begin
            errors++;
            $display("error %0t: status busy bit differs from av_write", $time);
        end
    core_holds: assert property (@(posedge sysclk) disable iff (!arst_n)
        mcu_wait |-> !(reg_load || reg_read))
        else begin
            errors++;
            $display("error %0t: core strobe issued during a stall", $time);
        end

    // mid-cycle sample, mcu_wait then holds until the next rising edge
    task automatic wait_write_done();
        int cycles;
        cycles = 0;
        #10;
        while (mcu_wait) begin
            cycles++;
            if (cycles > 20) begin
                errors++;
                $display("timeout: mcu_wait stayed high, the bus write never completed");
                -> hung;
                forever @(negedge sysclk);
            end
            @(negedge sysclk);
            #10;
        end
        // past the completing edge
        @(posedge sysclk);
    endtask

    task automatic load_reg(input logic [reg_map_pkg::reg_idx_w-1:0] sel,
                            input logic [reg_map_pkg::word_w-1:0] value);
        @(negedge sysclk);
        reg_sel = sel;
        load_data = value;
        reg_load = 1'b1;
        @(negedge sysclk);
        reg_load = 1'b0;
        if (sel == reg_map_pkg::r_av_address) begin
            exp_addr = value;
        end
        if (sel == reg_map_pkg::r_av_writedata) begin
            exp_writes.push_back({exp_addr, value});
            // status stays selected so the busy bit is watched
            reg_sel = reg_map_pkg::r_av_status;
            wait_write_done();
        end
    endtask

    // pop set issues a read strobe, otherwise just selects
    task automatic read_check(input logic [reg_map_pkg::reg_idx_w-1:0] sel,
                              input logic [reg_map_pkg::word_w-1:0] exp,
                              input bit pop, input string what);
        logic [reg_map_pkg::word_w-1:0] got;
        @(negedge sysclk);
        reg_sel = sel;
        reg_read = pop;
        #10;
        got = read_data;
        assert (got == exp) else begin
            errors++;
            $display("error %0t: %s, index %0d reads %h, expected %h", $time, what, sel, got, exp);
        end
        @(negedge sysclk);
        reg_read = 1'b0;
    endtask

    // old value through two rising edges, new value after the second
    task automatic key_check(input logic [1:0] new_key, input logic [1:0] old_key);
        @(negedge sysclk);
        reg_sel = reg_map_pkg::r_keys;
        key = new_key;
        repeat (2) begin
            #10;
            assert (read_data == 16'(old_key)) else begin
                errors++;
                $display("error %0t: key change seen before two edges", $time);
            end
            @(negedge sysclk);
        end
        #10;
        assert (read_data == 16'(new_key)) else begin
            errors++;
            $display("error %0t: key reads %h, expected %h", $time, read_data, new_key);
        end
    endtask

    initial begin : watchdog
        @(hung);
        $display("errors: %0d", errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [reg_map_pkg::reg_idx_w-1:0] idx;
        logic [reg_map_pkg::word_w-1:0] gp_model [reg_map_pkg::gp_count];
        logic [reg_map_pkg::word_w-1:0] stk_model [$];
        logic [reg_map_pkg::word_w-1:0] value;
        arst_n = 1'b0;
        reg_sel = '0;
        reg_load = 1'b0;
        reg_read = 1'b0;
        load_data = '0;
        key = 2'b00;
        repeat (16) @(negedge sysclk);
        arst_n = 1'b1;
        // synchronized reset releases on the third edge
        repeat (4) @(negedge sysclk);

        // reset state, every index reads zero without popping
        assert (led == '0 && !av_write && !mcu_wait) else begin
            errors++;
            $display("error %0t: outputs not low after reset", $time);
        end
        for (int i = 0; i < (1 << reg_map_pkg::reg_idx_w); i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            read_check(idx, '0, 1'b0, "reset value");
        end

        // general purpose bank, then one reload
        for (int i = 0; i < reg_map_pkg::gp_count; i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            gp_model[i] = 16'hc0de ^ {4{idx}};
            load_reg(reg_map_pkg::r_gp0 + idx, gp_model[i]);
        end
        gp_model[2] = 16'h3e21;
        load_reg(reg_map_pkg::r_gp0 + 4'd2, gp_model[2]);
        for (int i = 0; i < reg_map_pkg::gp_count; i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            read_check(reg_map_pkg::r_gp0 + idx, gp_model[i], 1'b1, "gp register");
        end
        // unused window ignores loads
        for (int i = 10; i < 16; i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            load_reg(idx, 16'hffff);
            read_check(idx, '0, 1'b1, "unused index");
        end

        // return stack, top checked after each push, then LIFO pops
        for (int i = 0; i < 6; i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            value = 16'h0a50 | {12'h000, idx};
            load_reg(reg_map_pkg::r_rstk, value);
            stk_model.push_back(value);
            read_check(reg_map_pkg::r_rstk, value, 1'b0, "stack top after push");
        end
        while (stk_model.size() > 0) begin
            read_check(reg_map_pkg::r_rstk, stk_model.pop_back(), 1'b1, "stack pop");
        end

        // leds truncate to led_width, read back zero extended
        load_reg(reg_map_pkg::r_leds, 16'ha5c3);
        assert (led == led_width'(16'ha5c3)) else begin
            errors++;
            $display("error %0t: led shows %h", $time, led);
        end
        read_check(reg_map_pkg::r_leds, 16'(led_width'(16'ha5c3)), 1'b1, "led register");
        key_check(2'b10, 2'b00);
        key_check(2'b01, 2'b10);

        // bus writes with random slave latency, address changed halfway
        load_reg(reg_map_pkg::r_av_address, 16'h4000);
        for (int i = 0; i < 8; i++) begin
            idx = i[reg_map_pkg::reg_idx_w-1:0];
            if (i == 4) begin
                load_reg(reg_map_pkg::r_av_address, 16'h4abc);
            end
            value = 16'h9000 | {8'h00, idx, ~idx};
            load_reg(reg_map_pkg::r_av_writedata, value);
            // first strobes after the stall
            read_check(reg_map_pkg::r_av_writedata, value, 1'b1, "bus write data");
        end
        read_check(reg_map_pkg::r_av_address, 16'h4abc, 1'b1, "bus address");
        read_check(reg_map_pkg::r_av_status, '0, 1'b1, "bus status when idle");
        load_reg(reg_map_pkg::r_gp0 + 4'd1, 16'h7e57);
        read_check(reg_map_pkg::r_gp0 + 4'd1, 16'h7e57, 1'b1, "gp register after writes");

        // one completed write per data load, in order
        assert (got_writes.size() == exp_writes.size()) else begin
            errors++;
            $display("error %0t: %0d bus writes completed, %0d expected",
                     $time, got_writes.size(), exp_writes.size());
        end
        for (int i = 0; i < got_writes.size() && i < exp_writes.size(); i++) begin
            assert (got_writes[i] == exp_writes[i]) else begin
                errors++;
                $display("error %0t: bus write %0d carried %h, expected %h",
                         $time, i, got_writes[i], exp_writes[i]);
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
reg_map_pkg.sv
bus_pkg.sv
reset_sync.sv
reg_access_decode.sv
gp_reg_bank.sv
stack_reg.sv
io_port_regs.sv
av_write_master.sv
mcu_io_top.sv
tb_mcu_io.sv

// ==== Makefile ====
TOP := tb_mcu_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
